// ==== coef_table_writer.sv ====
`timescale 1ns/1ps

module coef_table_writer #(
   parameter int ADDR_W = 8
) (
   input  logic                          clk,
   input  logic                          rst,
   input  para_pkg::load_section_e       section,
   input  logic                          coef_take,
   input  logic [ADDR_W:0]               coef_words,
   input  logic [para_pkg::DATA_W-1:0]   para_data,
   output logic                          bias_wr_en,
   output logic                          scale_wr_en,
   output logic                          shift_wr_en,
   output logic [ADDR_W-1:0]             wr_addr,
   output logic [para_pkg::DATA_W-1:0]   wr_data,
   output logic                          coef_last
);

   logic [ADDR_W-1:0] word_addr;
   logic [ADDR_W:0]   word_next;

   assign word_next = {1'b0, word_addr} + 1'b1;
   assign coef_last = (word_next == coef_words);

   // shared by bias, scale and shift, wraps at each table end
   always_ff @(posedge clk) begin
      if (rst || (section == para_pkg::SEC_IDLE)) begin
         word_addr <= '0;
      end else if (coef_take) begin
         word_addr <= coef_last ? '0 : word_addr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         bias_wr_en  <= 1'b0;
         scale_wr_en <= 1'b0;
         shift_wr_en <= 1'b0;
      end else begin
         bias_wr_en  <= coef_take && (section == para_pkg::SEC_BIAS);
         scale_wr_en <= coef_take && (section == para_pkg::SEC_SCALE);
         shift_wr_en <= coef_take && (section == para_pkg::SEC_SHIFT);
      end
   end

   always_ff @(posedge clk) begin
      wr_addr <= word_addr;
      wr_data <= para_data;
   end

   a_one_table_at_a_time: assert property (
      @(posedge clk) disable iff (rst)
      $onehot0({bias_wr_en, scale_wr_en, shift_wr_en})
   ) else $error("more than one coefficient table written at once");

endmodule

// ==== files.f ====
para_pkg.sv
param_ram.sv
load_sequencer.sv
weight_bank_writer.sv
coef_table_writer.sv
param_loader_top.sv
tb_clock_gen.sv
tb_param_loader.sv

// ==== load_sequencer.sv ====
`timescale 1ns/1ps

module load_sequencer (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    start,
   input  logic                    para_valid,
   input  logic                    weight_last,
   input  logic                    coef_last,
   output logic                    para_ready,
   output para_pkg::load_section_e section,
   output logic                    weight_take,
   output logic                    coef_take,
   output logic                    done
);

   logic accept;

   // a word moves on valid and ready together
   assign accept = para_valid && para_ready;

   assign weight_take = accept && (section == para_pkg::SEC_WEIGHT);
   assign coef_take   = accept && ((section == para_pkg::SEC_BIAS) ||
                                   (section == para_pkg::SEC_SCALE) ||
                                   (section == para_pkg::SEC_SHIFT));

   always_ff @(posedge clk) begin
      if (rst) begin
         section    <= para_pkg::SEC_IDLE;
         para_ready <= 1'b0;
         done       <= 1'b0;
      end else begin
         done <= 1'b0;
         case (section)
            para_pkg::SEC_IDLE: begin
               // start only counts while idle
               if (start) begin
                  section    <= para_pkg::SEC_WEIGHT;
                  para_ready <= 1'b1;
               end
            end
            para_pkg::SEC_WEIGHT: begin
               if (weight_take && weight_last) begin
                  section <= para_pkg::SEC_BIAS;
               end
            end
            para_pkg::SEC_BIAS: begin
               if (coef_take && coef_last) begin
                  section <= para_pkg::SEC_SCALE;
               end
            end
            para_pkg::SEC_SCALE: begin
               if (coef_take && coef_last) begin
                  section <= para_pkg::SEC_SHIFT;
               end
            end
            para_pkg::SEC_SHIFT: begin
               // last shift word closes the load
               if (coef_take && coef_last) begin
                  section    <= para_pkg::SEC_IDLE;
                  para_ready <= 1'b0;
                  done       <= 1'b1;
               end
            end
            default: begin
               section    <= para_pkg::SEC_IDLE;
               para_ready <= 1'b0;
            end
         endcase
      end
   end

   // ready must track the section register, never open outside a load
   a_ready_only_in_load: assert property (
      @(posedge clk) disable iff (rst)
      !(para_ready && (section == para_pkg::SEC_IDLE))
   ) else $error("para_ready high while section is idle");

endmodule

// ==== para_pkg.sv ====
package para_pkg;

   // stream word and RAM word width
   localparam int DATA_W = 64;

   // one weight bank per 3x3 tap
   localparam int KERNEL_NUM = 9;

   // address widths of a weight bank and of a coefficient table
   localparam int WEIGHT_ADDR_W = 10;
   localparam int COEF_ADDR_W = 8;

   // load section, in the order the stream fills them
   typedef enum logic [2:0] {
      SEC_IDLE   = 3'd0,
      SEC_WEIGHT = 3'd1,
      SEC_BIAS   = 3'd2,
      SEC_SCALE  = 3'd3,
      SEC_SHIFT  = 3'd4
   } load_section_e;

endpackage

// ==== param_loader_stim.txt ====
// hex words: load count, then per load weight_words, coef_words, base,
// weight readback count and addresses, coef readback count and addresses
2
// first load
10
8
a5a5000000000100
4
0
1
7
f
3
0
3
7
// second load, smaller sizes and a new base
a
5
3c3c000000002000
3
0
5
9
3
0
2
4

// ==== param_loader_top.sv ====
`timescale 1ns/1ps

module param_loader_top #(
   parameter int KERNEL_NUM    = para_pkg::KERNEL_NUM,
   parameter int WEIGHT_ADDR_W = para_pkg::WEIGHT_ADDR_W,
   parameter int COEF_ADDR_W   = para_pkg::COEF_ADDR_W
) (
   input  logic                                    clk,
   input  logic                                    rst,
   input  logic                                    start,
   input  logic [para_pkg::DATA_W-1:0]             para_data,
   input  logic                                    para_valid,
   output logic                                    para_ready,
   input  logic [WEIGHT_ADDR_W:0]                  weight_words,
   input  logic [COEF_ADDR_W:0]                    coef_words,
   output logic                                    done,
   input  logic [WEIGHT_ADDR_W-1:0]                weight_rd_addr,
   input  logic [COEF_ADDR_W-1:0]                  coef_rd_addr,
   output logic [KERNEL_NUM*para_pkg::DATA_W-1:0]  weight_rd_data,
   output logic [para_pkg::DATA_W-1:0]             bias_rd_data,
   output logic [para_pkg::DATA_W-1:0]             scale_rd_data,
   output logic [para_pkg::DATA_W-1:0]             shift_rd_data
);

   para_pkg::load_section_e section;
   logic                    weight_take;
   logic                    coef_take;
   logic                    weight_last;
   logic                    coef_last;

   logic [KERNEL_NUM-1:0]         weight_wr_en;
   logic [WEIGHT_ADDR_W-1:0]      weight_wr_addr;
   logic [para_pkg::DATA_W-1:0]   weight_wr_data;

   logic                          bias_wr_en;
   logic                          scale_wr_en;
   logic                          shift_wr_en;
   logic [COEF_ADDR_W-1:0]        coef_wr_addr;
   logic [para_pkg::DATA_W-1:0]   coef_wr_data;

   load_sequencer u_sequencer (
      .clk         (clk),
      .rst         (rst),
      .start       (start),
      .para_valid  (para_valid),
      .weight_last (weight_last),
      .coef_last   (coef_last),
      .para_ready  (para_ready),
      .section     (section),
      .weight_take (weight_take),
      .coef_take   (coef_take),
      .done        (done)
   );

   weight_bank_writer #(
      .BANK_NUM (KERNEL_NUM),
      .ADDR_W   (WEIGHT_ADDR_W)
   ) u_weight_writer (
      .clk          (clk),
      .rst          (rst),
      .section      (section),
      .weight_take  (weight_take),
      .weight_words (weight_words),
      .para_data    (para_data),
      .wr_en        (weight_wr_en),
      .wr_addr      (weight_wr_addr),
      .wr_data      (weight_wr_data),
      .weight_last  (weight_last)
   );

   coef_table_writer #(
      .ADDR_W (COEF_ADDR_W)
   ) u_coef_writer (
      .clk         (clk),
      .rst         (rst),
      .section     (section),
      .coef_take   (coef_take),
      .coef_words  (coef_words),
      .para_data   (para_data),
      .bias_wr_en  (bias_wr_en),
      .scale_wr_en (scale_wr_en),
      .shift_wr_en (shift_wr_en),
      .wr_addr     (coef_wr_addr),
      .wr_data     (coef_wr_data),
      .coef_last   (coef_last)
   );

   // bank 0 sits in the low bits of weight_rd_data
   for (genvar b = 0; b < KERNEL_NUM; b++) begin : g_weight_bank
      param_ram #(
         .DATA_W (para_pkg::DATA_W),
         .ADDR_W (WEIGHT_ADDR_W)
      ) u_bank (
         .clk     (clk),
         .we      (weight_wr_en[b]),
         .wr_addr (weight_wr_addr),
         .wr_data (weight_wr_data),
         .rd_addr (weight_rd_addr),
         .rd_data (weight_rd_data[b*para_pkg::DATA_W +: para_pkg::DATA_W])
      );
   end

   param_ram #(
      .DATA_W (para_pkg::DATA_W),
      .ADDR_W (COEF_ADDR_W)
   ) u_bias_table (
      .clk     (clk),
      .we      (bias_wr_en),
      .wr_addr (coef_wr_addr),
      .wr_data (coef_wr_data),
      .rd_addr (coef_rd_addr),
      .rd_data (bias_rd_data)
   );

   param_ram #(
      .DATA_W (para_pkg::DATA_W),
      .ADDR_W (COEF_ADDR_W)
   ) u_scale_table (
      .clk     (clk),
      .we      (scale_wr_en),
      .wr_addr (coef_wr_addr),
      .wr_data (coef_wr_data),
      .rd_addr (coef_rd_addr),
      .rd_data (scale_rd_data)
   );

   param_ram #(
      .DATA_W (para_pkg::DATA_W),
      .ADDR_W (COEF_ADDR_W)
   ) u_shift_table (
      .clk     (clk),
      .we      (shift_wr_en),
      .wr_addr (coef_wr_addr),
      .wr_data (coef_wr_data),
      .rd_addr (coef_rd_addr),
      .rd_data (shift_rd_data)
   );

endmodule

// ==== param_ram.sv ====
`timescale 1ns/1ps

module param_ram #(
   parameter int DATA_W = 64,
   parameter int ADDR_W = 10
) (
   input  logic              clk,
   input  logic              we,
   input  logic [ADDR_W-1:0] wr_addr,
   input  logic [DATA_W-1:0] wr_data,
   input  logic [ADDR_W-1:0] rd_addr,
   output logic [DATA_W-1:0] rd_data
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // registered read, data one cycle after the address
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_param_loader -f files.f \
   -o tb_param_loader > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_param_loader > sim.log 2>&1
cat sim.log
grep -q "Simulation passed" sim.log && exit 0 || exit 1

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic rst
);

   // 8 ns period
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // reset held for the first 8 rising edges
   initial begin
      rst = 1'b1;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

// ==== tb_param_loader.sv ====
`timescale 1ns/1ps

module tb_param_loader;

   localparam int DW = para_pkg::DATA_W;
   localparam int KN = para_pkg::KERNEL_NUM;

   logic                                   clk;
   logic                                   rst;
   logic                                   start;
   logic [DW-1:0]                          para_data;
   logic                                   para_valid;
   logic                                   para_ready;
   logic [para_pkg::WEIGHT_ADDR_W:0]       weight_words;
   logic [para_pkg::COEF_ADDR_W:0]         coef_words;
   logic                                   done;
   logic [para_pkg::WEIGHT_ADDR_W-1:0]     weight_rd_addr;
   logic [para_pkg::COEF_ADDR_W-1:0]       coef_rd_addr;
   logic [KN*DW-1:0]                       weight_rd_data;
   logic [DW-1:0]                          bias_rd_data;
   logic [DW-1:0]                          scale_rd_data;
   logic [DW-1:0]                          shift_rd_data;

   logic [63:0] stim [0:63];
   int          ptr;
   int          accept_count;
   int          done_count;

   tb_clock_gen u_clk_gen (
      .clk (clk),
      .rst (rst)
   );

   param_loader_top UUT (
      .clk            (clk),
      .rst            (rst),
      .start          (start),
      .para_data      (para_data),
      .para_valid     (para_valid),
      .para_ready     (para_ready),
      .weight_words   (weight_words),
      .coef_words     (coef_words),
      .done           (done),
      .weight_rd_addr (weight_rd_addr),
      .coef_rd_addr   (coef_rd_addr),
      .weight_rd_data (weight_rd_data),
      .bias_rd_data   (bias_rd_data),
      .scale_rd_data  (scale_rd_data),
      .shift_rd_data  (shift_rd_data)
   );

   // independent count of handshakes and done pulses
   always @(posedge clk) begin
      if (!rst && para_valid && para_ready) accept_count++;
      if (!rst && done) done_count++;
   end

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1, "stopping");
   endtask

   task automatic check_word(input string name, input logic [DW-1:0] got,
                             input logic [DW-1:0] exp);
      if (got !== exp) begin
         $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
         $display("Simulation failed");
         $fatal(1, "stopping");
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL time=%0t %s got=%b expected=%b", $time, name, got, exp);
         $display("Simulation failed");
         $fatal(1, "stopping");
      end
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > 100) report_failure("reset never released");
      end while (rst);
   endtask

   task automatic run_load(input int ww, input int cw, input logic [63:0] base,
                           input bit pulse_mid);
      int total;
      int word_idx;
      int cycles;
      bit mid_sent;
      total = KN * ww + 3 * cw;
      word_idx = 0;
      cycles = 0;
      mid_sent = 1'b0;
      accept_count = 0;
      done_count = 0;
      @(posedge clk);
      start <= 1'b1;
      para_valid <= 1'b0;
      para_data <= base;
      while (word_idx < total) begin
         @(posedge clk);
         cycles++;
         if (cycles > total * 8 + 100) report_failure("timeout while streaming words");
         // no stall inside a load
         if (word_idx > 0) check_bit("para_ready", para_ready, 1'b1);
         if (para_valid && para_ready) word_idx++;
         start <= 1'b0;
         // a stray start in the middle of the load
         if (pulse_mid && !mid_sent && word_idx >= total / 2) begin
            start <= 1'b1;
            mid_sent = 1'b1;
         end
         if (word_idx < total) begin
            para_data  <= base + 64'(word_idx);
            para_valid <= ($urandom % 32'd4) != 32'd0;
         end else begin
            // keep offering a word that must not be taken
            para_data  <= base + 64'(total);
            para_valid <= 1'b1;
         end
      end
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > 20) report_failure("timeout waiting for done after the last word");
      end while (!done);
      check_word("done latency", 64'(cycles), 64'd1);
      repeat (4) begin
         @(posedge clk);
         check_bit("para_ready", para_ready, 1'b0);
      end
      para_valid <= 1'b0;
      check_word("accepted words", 64'(accept_count), 64'(total));
      check_word("done pulses", 64'(done_count), 64'd1);
   endtask

   task automatic read_weights(input int ww, input logic [63:0] base);
      int n;
      int a;
      n = int'(stim[ptr]);
      ptr++;
      for (int i = 0; i < n; i++) begin
         a = int'(stim[ptr]);
         ptr++;
         weight_rd_addr <= stim[ptr-1][para_pkg::WEIGHT_ADDR_W-1:0];
         @(posedge clk);
         @(posedge clk);
         for (int b = 0; b < KN; b++) begin
            check_word($sformatf("weight_rd_data bank %0d addr %0d", b, a),
                       weight_rd_data[b*DW +: DW], base + 64'(b * ww + a));
         end
      end
   endtask

   task automatic read_tables(input int ww, input int cw, input logic [63:0] base);
      int n;
      int a;
      int first;
      n = int'(stim[ptr]);
      ptr++;
      first = KN * ww;
      for (int i = 0; i < n; i++) begin
         a = int'(stim[ptr]);
         ptr++;
         coef_rd_addr <= stim[ptr-1][para_pkg::COEF_ADDR_W-1:0];
         @(posedge clk);
         @(posedge clk);
         check_word($sformatf("bias_rd_data addr %0d", a), bias_rd_data,
                    base + 64'(first + a));
         check_word($sformatf("scale_rd_data addr %0d", a), scale_rd_data,
                    base + 64'(first + cw + a));
         check_word($sformatf("shift_rd_data addr %0d", a), shift_rd_data,
                    base + 64'(first + 2 * cw + a));
      end
   endtask

   initial begin
      int n_loads;
      int ww;
      int cw;
      logic [63:0] base;
      start          = 1'b0;
      para_data      = '0;
      para_valid     = 1'b0;
      weight_words   = '0;
      coef_words     = '0;
      weight_rd_addr = '0;
      coef_rd_addr   = '0;
      accept_count   = 0;
      done_count     = 0;
      void'($urandom(32'h37bb));
      $readmemh("param_loader_stim.txt", stim);
      // an unread file leaves the load count unknown or zero
      if ($isunknown(stim[0]) || (stim[0] == 64'd0)) begin
         report_failure("stim file could not be read or holds no load");
      end
      wait_reset_release();
      // quiet until the first start
      repeat (6) begin
         @(posedge clk);
         check_bit("para_ready", para_ready, 1'b0);
         check_bit("done", done, 1'b0);
      end
      n_loads = int'(stim[0]);
      ptr = 1;
      for (int l = 0; l < n_loads; l++) begin
         ww   = int'(stim[ptr]);
         cw   = int'(stim[ptr+1]);
         base = stim[ptr+2];
         ptr  = ptr + 3;
         weight_words <= ww[para_pkg::WEIGHT_ADDR_W:0];
         coef_words   <= cw[para_pkg::COEF_ADDR_W:0];
         run_load(ww, cw, base, l == 0);
         read_weights(ww, base);
         read_tables(ww, cw, base);
      end
      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== weight_bank_writer.sv ====
`timescale 1ns/1ps

module weight_bank_writer #(
   parameter int BANK_NUM = 9,
   parameter int ADDR_W   = 10
) (
   input  logic                          clk,
   input  logic                          rst,
   input  para_pkg::load_section_e       section,
   input  logic                          weight_take,
   input  logic [ADDR_W:0]               weight_words,
   input  logic [para_pkg::DATA_W-1:0]   para_data,
   output logic [BANK_NUM-1:0]           wr_en,
   output logic [ADDR_W-1:0]             wr_addr,
   output logic [para_pkg::DATA_W-1:0]   wr_data,
   output logic                          weight_last
);

   logic [ADDR_W-1:0]   word_addr;
   logic [ADDR_W:0]     word_next;
   logic                bank_full;
   logic [BANK_NUM-1:0] bank_ptr;

   // one wider so a full 2**ADDR_W bank can be matched
   assign word_next = {1'b0, word_addr} + 1'b1;
   assign bank_full = (word_next == weight_words);

   // final word of the last bank
   assign weight_last = bank_full && bank_ptr[BANK_NUM-1];

   always_ff @(posedge clk) begin
      if (rst || (section == para_pkg::SEC_IDLE)) begin
         word_addr <= '0;
         bank_ptr  <= {{(BANK_NUM-1){1'b0}}, 1'b1};
      end else if (weight_take) begin
         if (bank_full) begin
            word_addr <= '0;
            bank_ptr  <= {bank_ptr[BANK_NUM-2:0], bank_ptr[BANK_NUM-1]};
         end else begin
            word_addr <= word_addr + 1'b1;
         end
      end
   end

   // write lands in the bank one cycle after acceptance
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_en <= '0;
      end else begin
         wr_en <= weight_take ? bank_ptr : '0;
      end
   end

   always_ff @(posedge clk) begin
      wr_addr <= word_addr;
      wr_data <= para_data;
   end

   a_bank_ptr_onehot: assert property (
      @(posedge clk) disable iff (rst)
      $onehot(bank_ptr)
   ) else $error("weight bank pointer lost its one-hot state");

endmodule
